/* hdl/line_code_pkg.sv */
package line_code_pkg;

	localparam int SYM_W = 9;
	localparam int BYTE_W = 8;
	localparam int CODE_W = 10;

	// Symbols as they arrive on datain
	localparam logic [SYM_W-1:0] K28_1_IN = 9'h13C;
	localparam logic [SYM_W-1:0] K28_5_IN = 9'h1BC;

	// Byte values handed to the encoder with ctrl set
	localparam logic [BYTE_W-1:0] K28_5_BYTE = 8'hBC;
	localparam logic [BYTE_W-1:0] K23_7_BYTE = 8'hF7;

	// Code groups written abcdei / fghj with a leftmost, RD- forms
	localparam logic [5:0] D6_RDN [0:31] = '{
		6'b100111, 6'b011101, 6'b101101, 6'b110001,
		6'b110101, 6'b101001, 6'b011001, 6'b111000,
		6'b111001, 6'b100101, 6'b010101, 6'b110100,
		6'b001101, 6'b101100, 6'b011100, 6'b010111,
		6'b011011, 6'b100011, 6'b010011, 6'b110010,
		6'b001011, 6'b101010, 6'b011010, 6'b111010,
		6'b110011, 6'b100110, 6'b010110, 6'b110110,
		6'b001110, 6'b101110, 6'b011110, 6'b101011
	};
	localparam logic [5:0] K28_ABCDEI = 6'b001111;

	// D.x.7 uses the primary code from this table
	localparam logic [3:0] D4_RDN [0:7] = '{
		4'b1011, 4'b1001, 4'b0101, 4'b1100,
		4'b1101, 4'b1010, 4'b0110, 4'b1110
	};
	localparam logic [3:0] A7_RDN = 4'b0111;

	// K28.y and Kx.7, RD+ form is the full complement
	localparam logic [3:0] K_FGHJ_RDN [0:7] = '{
		4'b0100, 4'b1001, 4'b0101, 4'b0011,
		4'b0010, 4'b1010, 4'b0110, 4'b1000
	};

	function automatic logic ctrl_byte_ok(input logic [BYTE_W-1:0] b);
		case (b)
			8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hDC, 8'hFC: return 1'b1;
			8'hF7, 8'hFB, 8'hFD, 8'hFE: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

endpackage

/* hdl/frame_pkg.sv */
package frame_pkg;

	// Framing
	localparam int PREAMBLE_LEN = 4;
	localparam int CRC_BYTES = 4;
	localparam int CNT_W = 3;

	// Reflected Ethernet CRC-32
	localparam int CRC_W = 32;
	localparam int CRC_BYTE_W = CRC_W / CRC_BYTES;
	localparam logic [CRC_W-1:0] CRC_INIT = 32'hFFFF_FFFF;
	localparam logic [CRC_W-1:0] CRC_POLY = 32'hEDB8_8320;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_PREAMBLE,
		ST_DATA,
		ST_CRC,
		ST_CLOSE
	} frame_state_t;

endpackage

/* hdl/frame_counter.sv */
`timescale 1ns/1ps

module frame_counter import frame_pkg::*; (
	input logic clk,
	input logic reset,
	input logic load,
	input logic [CNT_W-1:0] len,
	input logic step,
	output logic done
);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= len;
		end else if (step) begin
			cnt <= cnt - 1'b1;
		end
	end

	// Last step of the run
	assign done = (cnt == CNT_W'(1));

	assert property (@(posedge clk) disable iff (reset)
		step |-> cnt != '0);

endmodule

/* hdl/crc32_accum.sv */
`timescale 1ns/1ps

module crc32_accum import frame_pkg::*; (
	input logic clk,
	input logic reset,
	input logic init,
	input logic update,
	input logic shift,
	input logic [CRC_BYTE_W-1:0] data_byte,
	output logic [CRC_BYTE_W-1:0] crc_byte
);

	logic [CRC_W-1:0] crc;
	logic [CRC_W-1:0] crc_next;

	// One bit per step, LSB first
	always_comb begin
		crc_next = crc ^ {{(CRC_W - CRC_BYTE_W){1'b0}}, data_byte};
		for (int i = 0; i < CRC_BYTE_W; i++) begin
			crc_next = crc_next[0] ? ((crc_next >> 1) ^ CRC_POLY) : (crc_next >> 1);
		end
	end

	always_ff @(posedge clk) begin
		if (reset || init) begin
			crc <= CRC_INIT;
		end else if (update) begin
			crc <= crc_next;
		end else if (shift) begin
			// Ones fill so the inverted trailer reads zero past the end
			crc <= {{CRC_BYTE_W{1'b1}}, crc[CRC_W-1:CRC_BYTE_W]};
		end
	end

	assign crc_byte = ~crc[CRC_BYTE_W-1:0];

	assert property (@(posedge clk) disable iff (reset)
		!(update && shift));

endmodule

/* hdl/enc_8b10b.sv */
`timescale 1ns/1ps

module enc_8b10b import line_code_pkg::*; (
	input logic clk,
	input logic reset,
	input logic push,
	input logic start,
	input logic ctrl,
	input logic [BYTE_W-1:0] data_byte,
	output logic pushout,
	output logic startout,
	output logic [CODE_W-1:0] dataout
);

	// Running disparity, 0 is negative
	logic rd;
	logic rd6;
	logic rd_next;
	logic [4:0] x;
	logic [2:0] y;
	logic [5:0] d6_n;
	logic d6_bal;
	logic use_a7;
	logic [3:0] d4_n;
	logic [5:0] d6;
	logic [3:0] d4;
	logic [5:0] k6_n;
	logic [3:0] k4_n;
	logic [5:0] abcdei;
	logic [3:0] fghj;
	logic [CODE_W-1:0] code;

	assign x = data_byte[4:0];
	assign y = data_byte[7:5];

	// 5b/6b for data
	assign d6_n = D6_RDN[x];
	assign d6_bal = ($countones(d6_n) == 3);
	assign d6 = (rd && (!d6_bal || x == 5'd7)) ? ~d6_n : d6_n;
	assign rd6 = d6_bal ? rd : ~rd;

	// 3b/4b, alternate x.7 avoids a run of five
	assign use_a7 = (!rd6 && (x == 5'd17 || x == 5'd18 || x == 5'd20))
		|| (rd6 && (x == 5'd11 || x == 5'd13 || x == 5'd14));
	assign d4_n = (y == 3'd7 && use_a7) ? A7_RDN : D4_RDN[y];
	assign d4 = (rd6 && ($countones(d4_n) != 2 || y == 3'd3)) ? ~d4_n : d4_n;

	// Control groups
	assign k6_n = (x == 5'd28) ? K28_ABCDEI : d6_n;
	assign k4_n = K_FGHJ_RDN[y];

	assign abcdei = ctrl ? (rd ? ~k6_n : k6_n) : d6;
	assign fghj = ctrl ? (rd ? ~k4_n : k4_n) : d4;

	// Bit a goes out first in bit 0
	always_comb begin
		for (int i = 0; i < 6; i++) begin
			code[i] = abcdei[5 - i];
		end
		for (int i = 0; i < 4; i++) begin
			code[6 + i] = fghj[3 - i];
		end
	end

	assign rd_next = ($countones(code) == 5) ? rd : ~rd;

	always_ff @(posedge clk) begin
		if (reset) begin
			pushout <= 1'b0;
			startout <= 1'b0;
			dataout <= '0;
			rd <= 1'b0;
		end else begin
			pushout <= push;
			startout <= push && start;
			if (push) begin
				dataout <= code;
				rd <= rd_next;
			end
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		push |=> $countones(dataout) inside {[4:6]});

endmodule

/* hdl/frame_fsm.sv */
`timescale 1ns/1ps

module frame_fsm import line_code_pkg::*, frame_pkg::*; (
	input logic clk,
	input logic reset,
	input logic pushin,
	input logic startin,
	input logic [SYM_W-1:0] datain,
	input logic cnt_done,
	input logic [BYTE_W-1:0] crc_byte,
	output logic enc_push,
	output logic enc_start,
	output logic enc_ctrl,
	output logic [BYTE_W-1:0] enc_byte,
	output logic cnt_load,
	output logic [CNT_W-1:0] cnt_len,
	output logic cnt_step,
	output logic crc_init,
	output logic crc_update,
	output logic crc_shift
);

	frame_state_t state;
	frame_state_t next_state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		enc_push = 1'b0;
		enc_start = 1'b0;
		enc_ctrl = 1'b0;
		enc_byte = datain[BYTE_W-1:0];
		cnt_load = 1'b0;
		cnt_len = CNT_W'(PREAMBLE_LEN - 1);
		cnt_step = 1'b0;
		crc_init = 1'b0;
		crc_update = 1'b0;
		crc_shift = 1'b0;
		case (state)
			ST_IDLE: begin
				if (pushin && startin && datain == K28_1_IN) begin
					enc_push = 1'b1;
					enc_start = 1'b1;
					enc_ctrl = 1'b1;
					cnt_load = 1'b1;
					crc_init = 1'b1;
					next_state = ST_PREAMBLE;
				end
			end
			ST_PREAMBLE: begin
				// Anything but K28.1 drops the frame silently
				if (pushin) begin
					if (datain == K28_1_IN) begin
						enc_push = 1'b1;
						enc_ctrl = 1'b1;
						cnt_step = 1'b1;
						if (cnt_done) begin
							next_state = ST_DATA;
						end
					end else begin
						next_state = ST_IDLE;
					end
				end
			end
			ST_DATA: begin
				if (pushin) begin
					if (datain == K28_5_IN) begin
						enc_push = 1'b1;
						enc_ctrl = 1'b1;
						enc_byte = K23_7_BYTE;
						cnt_load = 1'b1;
						cnt_len = CNT_W'(CRC_BYTES);
						next_state = ST_CRC;
					end else if (!datain[SYM_W-1]) begin
						enc_push = 1'b1;
						crc_update = 1'b1;
					end else if (ctrl_byte_ok(datain[BYTE_W-1:0])) begin
						enc_push = 1'b1;
						enc_ctrl = 1'b1;
					end
				end
			end
			ST_CRC: begin
				// Low byte first, one per cycle
				enc_push = 1'b1;
				enc_byte = crc_byte;
				crc_shift = 1'b1;
				cnt_step = 1'b1;
				if (cnt_done) begin
					next_state = ST_CLOSE;
				end
			end
			ST_CLOSE: begin
				enc_push = 1'b1;
				enc_ctrl = 1'b1;
				enc_byte = K28_5_BYTE;
				next_state = ST_IDLE;
			end
			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

	// Trailer is exactly CRC_BYTES symbols long
	assert property (@(posedge clk) disable iff (reset)
		(state == ST_CLOSE) |-> ($past(state, CRC_BYTES) == ST_CRC)
			&& ($past(state, CRC_BYTES + 1) == ST_DATA));

endmodule

/* hdl/enc_top.sv */
`timescale 1ns/1ps

module enc_top import line_code_pkg::*, frame_pkg::*; (
	input logic clk,
	input logic reset,
	input logic pushin,
	input logic startin,
	input logic [SYM_W-1:0] datain,
	output logic pushout,
	output logic startout,
	output logic [CODE_W-1:0] dataout
);

	logic enc_push;
	logic enc_start;
	logic enc_ctrl;
	logic [BYTE_W-1:0] enc_byte;
	logic cnt_load;
	logic [CNT_W-1:0] cnt_len;
	logic cnt_step;
	logic cnt_done;
	logic crc_init;
	logic crc_update;
	logic crc_shift;
	logic [BYTE_W-1:0] crc_byte;

	frame_fsm u_fsm (
		.clk(clk),
		.reset(reset),
		.pushin(pushin),
		.startin(startin),
		.datain(datain),
		.cnt_done(cnt_done),
		.crc_byte(crc_byte),
		.enc_push(enc_push),
		.enc_start(enc_start),
		.enc_ctrl(enc_ctrl),
		.enc_byte(enc_byte),
		.cnt_load(cnt_load),
		.cnt_len(cnt_len),
		.cnt_step(cnt_step),
		.crc_init(crc_init),
		.crc_update(crc_update),
		.crc_shift(crc_shift)
	);

	frame_counter u_cnt (
		.clk(clk),
		.reset(reset),
		.load(cnt_load),
		.len(cnt_len),
		.step(cnt_step),
		.done(cnt_done)
	);

	// Data bytes reach the CRC through the encoder request
	crc32_accum u_crc (
		.clk(clk),
		.reset(reset),
		.init(crc_init),
		.update(crc_update),
		.shift(crc_shift),
		.data_byte(enc_byte),
		.crc_byte(crc_byte)
	);

	enc_8b10b u_enc (
		.clk(clk),
		.reset(reset),
		.push(enc_push),
		.start(enc_start),
		.ctrl(enc_ctrl),
		.data_byte(enc_byte),
		.pushout(pushout),
		.startout(startout),
		.dataout(dataout)
	);

endmodule

/* sim/tb_code_model.svh */
`ifndef TB_CODE_MODEL_SVH
`define TB_CODE_MODEL_SVH

// 5b/6b code groups, RD- form, a is the leftmost bit
function automatic logic [5:0] rdn_6b(input logic [4:0] x);
	case (x)
		5'd0: return 6'b100111;
		5'd1: return 6'b011101;
		5'd2: return 6'b101101;
		5'd3: return 6'b110001;
		5'd4: return 6'b110101;
		5'd5: return 6'b101001;
		5'd6: return 6'b011001;
		5'd7: return 6'b111000;
		5'd8: return 6'b111001;
		5'd9: return 6'b100101;
		5'd10: return 6'b010101;
		5'd11: return 6'b110100;
		5'd12: return 6'b001101;
		5'd13: return 6'b101100;
		5'd14: return 6'b011100;
		5'd15: return 6'b010111;
		5'd16: return 6'b011011;
		5'd17: return 6'b100011;
		5'd18: return 6'b010011;
		5'd19: return 6'b110010;
		5'd20: return 6'b001011;
		5'd21: return 6'b101010;
		5'd22: return 6'b011010;
		5'd23: return 6'b111010;
		5'd24: return 6'b110011;
		5'd25: return 6'b100110;
		5'd26: return 6'b010110;
		5'd27: return 6'b110110;
		5'd28: return 6'b001110;
		5'd29: return 6'b101110;
		5'd30: return 6'b011110;
		default: return 6'b101011;
	endcase
endfunction

// 3b/4b, RD- form, primary x.7
function automatic logic [3:0] rdn_4b(input logic [2:0] y);
	case (y)
		3'd0: return 4'b1011;
		3'd1: return 4'b1001;
		3'd2: return 4'b0101;
		3'd3: return 4'b1100;
		3'd4: return 4'b1101;
		3'd5: return 4'b1010;
		3'd6: return 4'b0110;
		default: return 4'b1110;
	endcase
endfunction

// K-code fghj, RD- form
function automatic logic [3:0] rdn_k4b(input logic [2:0] y);
	case (y)
		3'd0: return 4'b0100;
		3'd1: return 4'b1001;
		3'd2: return 4'b0101;
		3'd3: return 4'b0011;
		3'd4: return 4'b0010;
		3'd5: return 4'b1010;
		3'd6: return 4'b0110;
		default: return 4'b1000;
	endcase
endfunction

// Returns the 10-bit code with bit a in bit 0
function automatic logic [9:0] encode_symbol(input logic k, input logic [7:0] b, input logic rd);
	logic [4:0] x;
	logic [2:0] y;
	logic [5:0] s6;
	logic [3:0] s4;
	logic rd_mid;
	logic [9:0] seq;
	logic [9:0] code;
	x = b[4:0];
	y = b[7:5];
	if (k) begin
		s6 = (x == 5'd28) ? 6'b001111 : rdn_6b(x);
		s4 = rdn_k4b(y);
		if (rd) begin
			s6 = ~s6;
			s4 = ~s4;
		end
	end else begin
		s6 = rdn_6b(x);
		if (rd && ($countones(s6) != 3 || x == 5'd7))
			s6 = ~s6;
		rd_mid = ($countones(s6) == 3) ? rd : ~rd;
		if (y == 3'd7 && ((!rd_mid && (x == 5'd17 || x == 5'd18 || x == 5'd20))
				|| (rd_mid && (x == 5'd11 || x == 5'd13 || x == 5'd14))))
			s4 = 4'b0111;
		else
			s4 = rdn_4b(y);
		if (rd_mid && ($countones(s4) != 2 || y == 3'd3))
			s4 = ~s4;
	end
	seq = {s6, s4};
	for (int i = 0; i < 10; i++) begin
		code[i] = seq[9 - i];
	end
	return code;
endfunction

function automatic logic rd_after(input logic [9:0] code, input logic rd);
	return ($countones(code) == 5) ? rd : ~rd;
endfunction

// Reflected CRC-32, one input bit at a time, LSB first
function automatic logic [31:0] crc_add_byte(input logic [31:0] c, input logic [7:0] b);
	logic [31:0] r;
	logic fb;
	r = c;
	for (int i = 0; i < 8; i++) begin
		fb = r[0] ^ b[i];
		r = r >> 1;
		if (fb)
			r = r ^ CRC_POLY;
	end
	return r;
endfunction

// Taps 32, 22, 2, 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

/* sim/tb_enc_top.sv */
`timescale 1ns/1ps

module tb_enc_top import line_code_pkg::*, frame_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int NUM_FRAMES = 12;
	localparam int MAX_FRAME_CYCLES = 200;
	localparam int MARGIN_CYCLES = 100;
	localparam logic [31:0] LFSR_SEED = 32'hbb05_5a96;
	localparam logic [7:0] CTRL_LIST [0:10] = '{
		8'h1C, 8'h3C, 8'h5C, 8'h7C, 8'h9C, 8'hDC, 8'hFC, 8'hF7, 8'hFB, 8'hFD, 8'hFE
	};

	logic clk;
	logic reset;
	logic pushin;
	logic startin;
	logic [SYM_W-1:0] datain;
	logic pushout;
	logic startout;
	logic [CODE_W-1:0] dataout;

	logic [31:0] lfsr_state;
	int cyc;

	// Expected symbols in output order
	logic [SYM_W-1:0] sym_q [$];
	logic start_q [$];
	int cyc_q [$];
	string name_q [$];

	logic chk_valid;
	logic [CODE_W-1:0] exp_code;
	logic exp_start;
	int exp_cyc;
	int obs_cyc;
	string chk_name;
	logic model_rd;

	`include "tb_code_model.svh"

	enc_top dut (
		.clk(clk),
		.reset(reset),
		.pushin(pushin),
		.startin(startin),
		.datain(datain),
		.pushout(pushout),
		.startout(startout),
		.dataout(dataout)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic value_failed(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		fail_now($sformatf("CHECK FAILED %s expected %0h actual %0h", name, exp, act));
	endtask

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	task automatic drive(input logic push, input logic start, input logic [SYM_W-1:0] sym);
		@(posedge clk);
		#1;
		pushin = push;
		startin = start;
		datain = sym;
	endtask

	task automatic expect_sym(input logic [SYM_W-1:0] sym, input logic st, input int at,
			input string name);
		sym_q.push_back(sym);
		start_q.push_back(st);
		cyc_q.push_back(at);
		name_q.push_back(name);
	endtask

	task automatic send(input logic [SYM_W-1:0] sym, input logic start, input logic emitted,
			input string name);
		drive(1'b1, start, sym);
		if (emitted)
			expect_sym(sym, start, cyc + 1, name);
	endtask

	task automatic idle_gap();
		logic [31:0] r;
		r = rand_bits(3);
		if (r[2])
			repeat (int'(r[1:0])) drive(1'b0, 1'b0, SYM_W'(r[1:0]));
	endtask

	// break_at selects a preamble slot that gets a wrong symbol, -1 for none
	task automatic send_frame(input int break_at);
		logic [31:0] crc;
		logic [31:0] r;
		logic [31:0] trailer;
		int body_len;
		int d;
		crc = CRC_INIT;
		for (int i = 0; i < PREAMBLE_LEN; i++) begin
			idle_gap();
			if (i == break_at) begin
				r = rand_bits(8);
				send({1'b0, r[7:0]}, 1'b0, 1'b0, "broken preamble");
				return;
			end
			send(K28_1_IN, i == 0, 1'b1, "preamble");
		end
		r = rand_bits(5);
		body_len = int'(r[4:0]) + 1;
		for (int i = 0; i < body_len; i++) begin
			idle_gap();
			r = rand_bits(3);
			if (r[2:0] == 3'd0) begin
				r = rand_bits(4);
				send({1'b1, CTRL_LIST[int'(r[3:0]) % 11]}, 1'b0, 1'b1, "control");
			end else if (r[2:0] == 3'd1) begin
				// Not in the accepted list
				send(9'h100, 1'b0, 1'b0, "ignored control");
			end else begin
				r = rand_bits(8);
				crc = crc_add_byte(crc, r[7:0]);
				send({1'b0, r[7:0]}, 1'b0, 1'b1, "data");
			end
		end
		idle_gap();
		drive(1'b1, 1'b0, K28_5_IN);
		d = cyc;
		trailer = ~crc;
		expect_sym(9'h1F7, 1'b0, d + 1, "end symbol");
		for (int i = 0; i < CRC_BYTES; i++) begin
			expect_sym({1'b0, trailer[8*i +: 8]}, 1'b0, d + 2 + i, "crc");
		end
		expect_sym(K28_5_IN, 1'b0, d + 6, "close");
		repeat (5) drive(1'b0, 1'b0, '0);
	endtask

	// Pops the expected symbol for the code that just came out
	always @(negedge clk) begin
		logic [SYM_W-1:0] sym;
		chk_valid = 1'b0;
		if (!reset && pushout && sym_q.size() != 0) begin
			sym = sym_q.pop_front();
			exp_start = start_q.pop_front();
			exp_cyc = cyc_q.pop_front();
			chk_name = name_q.pop_front();
			exp_code = encode_symbol(sym[8], sym[7:0], model_rd);
			model_rd = rd_after(exp_code, model_rd);
			obs_cyc = cyc;
			chk_valid = 1'b1;
		end
	end

	assert property (@(posedge clk) reset |=> !pushout && !startout)
		else fail_now("Output strobe high during reset");

	assert property (@(posedge clk) disable iff (reset) pushout |-> chk_valid)
		else fail_now("DUT pushed a symbol when none was expected");

	assert property (@(posedge clk) disable iff (reset) !pushout |-> !startout)
		else fail_now("startout high without pushout");

	assert property (@(posedge clk) disable iff (reset)
		pushout && chk_valid |-> dataout == exp_code)
		else value_failed(chk_name, 32'(exp_code), 32'(dataout));

	assert property (@(posedge clk) disable iff (reset)
		pushout && chk_valid |-> startout == exp_start)
		else value_failed({chk_name, " startout"}, 32'(exp_start), 32'(startout));

	assert property (@(posedge clk) disable iff (reset)
		pushout && chk_valid |-> obs_cyc == exp_cyc)
		else value_failed({chk_name, " cycle"}, exp_cyc, obs_cyc);

	initial begin
		#(CLK_PERIOD * (RESET_CYCLES + NUM_FRAMES * MAX_FRAME_CYCLES + MARGIN_CYCLES));
		fail_now("Timeout, the run did not finish in time");
	end

	initial begin
		reset = 1'b1;
		pushin = 1'b0;
		startin = 1'b0;
		datain = '0;
		cyc = 0;
		model_rd = 1'b0;
		chk_valid = 1'b0;
		lfsr_state = LFSR_SEED;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int f = 0; f < NUM_FRAMES; f++) begin
			if (f == 3)
				send_frame(1);
			else if (f == 7)
				send_frame(3);
			else
				send_frame(-1);
		end
		while (sym_q.size() != 0) @(posedge clk);
		repeat (4) @(posedge clk);
		$display("No errors");
		$finish;
	end

endmodule

/* files.f */
+incdir+sim
hdl/line_code_pkg.sv
hdl/frame_pkg.sv
hdl/frame_counter.sv
hdl/crc32_accum.sv
hdl/enc_8b10b.sv
hdl/frame_fsm.sv
hdl/enc_top.sv
sim/tb_enc_top.sv

/* Makefile */
TOP ?= tb_enc_top
LOG ?= sim.log
VERILATOR ?= verilator
OBJ_DIR ?= obj_dir
FILELIST ?= files.f
VFLAGS ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "No errors" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
